// File: design/io_map_pkg.sv
// address map of the IO space seen by the CPU bus
// import into any block that decodes the bus or sizes its data path
package io_map_pkg;

	// bus widths
	localparam int DATA_BITS = 16;
	localparam int ADDR_BITS = 16;

	// top nibble of the address selects a 4 KB region
	localparam int REGION_BITS = 4;

	// low address bits passed on to a peripheral
	localparam int REG_OFFSET_BITS = 4;

	// region codes
	localparam logic [REGION_BITS-1:0] REGION_UART = 4'h0;	// 0x0000 - 0x0fff
	localparam logic [REGION_BITS-1:0] REGION_GPIO = 4'h1;	// 0x1000 - 0x1fff
	localparam logic [REGION_BITS-1:0] REGION_IRQ  = 4'h7;	// 0x7000 - 0x7fff

	// regions 2..6 and 8..f are unmapped and read as zero
	// the old pwm, audio, spi, gfx, trace and boot ram slots live there
	// a write to any of them is dropped in the decode

endpackage

// File: design/periph_regs_pkg.sv
// register offsets, bit positions and interrupt numbering of the peripherals
// offsets are relative to the start of each 4 KB region
package periph_regs_pkg;

	// uart
	localparam logic [3:0] UART_TXDATA = 4'd0;	// write starts a frame
	localparam logic [3:0] UART_STATUS = 4'd1;
	localparam int UART_STATUS_BUSY = 0;		// busy flag position

	// gpio
	localparam logic [3:0] GPIO_OUT      = 4'd0;
	localparam logic [3:0] GPIO_IN       = 4'd1;	// read only
	localparam logic [3:0] GPIO_IRQ_MASK = 4'd2;

	localparam int GPIO_OUT_BITS = 4;
	localparam int GPIO_IN_BITS  = 6;

	// interrupt controller
	localparam logic [3:0] IRQ_PENDING = 4'd0;	// write one to clear
	localparam logic [3:0] IRQ_ENABLE  = 4'd1;

	// interrupt source numbers, lower number wins
	localparam int IRQ_SRC_UART = 0;
	localparam int IRQ_SRC_GPIO = 1;

	// width of the irq_id output
	localparam int IRQ_ID_BITS = 2;

endpackage

// File: design/baud_timer.sv
// bit period counter for the UART
// counts while run is high and ticks once every CLKS_PER_BIT cycles
module baud_timer #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic CLK,
	input  logic RSTb,
	input  logic run,
	output logic baud_tick
);

	localparam int CNT_BITS = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [CNT_BITS-1:0] LAST = CNT_BITS'(CLKS_PER_BIT - 1);

	logic [CNT_BITS-1:0] count;

	// first tick lands CLKS_PER_BIT cycles after run rises
	assign baud_tick = run && (count == LAST);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			count <= '0;
		end else if (!run) begin
			count <= '0;	// idle, restart on next frame
		end else if (baud_tick) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

endmodule

// File: design/uart_tx_fsm.sv
// 8N1 UART transmitter driven by the baud tick from baud_timer
// a TXDATA write while idle starts a frame, busy is readable in STATUS
module uart_tx_fsm (
	input  logic                                   CLK,
	input  logic                                   RSTb,
	input  logic [io_map_pkg::REG_OFFSET_BITS-1:0] reg_addr,
	input  logic [io_map_pkg::DATA_BITS-1:0]       wdata,
	input  logic                                   wr,
	input  logic                                   baud_tick,
	output logic                                   run,
	output logic [io_map_pkg::DATA_BITS-1:0]       rdata,
	output logic                                   uart_tx,
	output logic                                   tx_done
);
	import io_map_pkg::*;
	import periph_regs_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP} state_t;

	state_t state;
	logic [7:0] shift;
	logic [2:0] bit_cnt;
	logic busy;

	assign busy    = (state != ST_IDLE);
	assign run     = busy;	// keeps the baud timer counting
	assign tx_done = (state == ST_STOP) && baud_tick;	// last cycle of stop bit

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state   <= ST_IDLE;
			uart_tx <= 1'b1;
			bit_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (wr && reg_addr == UART_TXDATA) begin
						shift   <= wdata[7:0];
						uart_tx <= 1'b0;	// start bit
						state   <= ST_START;
					end
				end
				ST_START: begin
					if (baud_tick) begin
						uart_tx <= shift[0];
						shift   <= shift >> 1;
						bit_cnt <= '0;
						state   <= ST_DATA;
					end
				end
				ST_DATA: begin
					if (baud_tick) begin
						if (bit_cnt == 3'd7) begin
							uart_tx <= 1'b1;	// stop bit
							state   <= ST_STOP;
						end else begin
							uart_tx <= shift[0];
							shift   <= shift >> 1;
							bit_cnt <= bit_cnt + 3'd1;
						end
					end
				end
				default: begin
					if (baud_tick)
						state <= ST_IDLE;
				end
			endcase
		end
	end

	always_comb begin
		rdata = '0;
		if (reg_addr == UART_STATUS)
			rdata[UART_STATUS_BUSY] = busy;
	end

endmodule

// File: design/gpio_port.sv
// gpio block with output register, synchronised inputs and edge interrupt
// a rising edge on an input whose mask bit is set gives a one cycle edge_irq
module gpio_port (
	input  logic                                     CLK,
	input  logic                                     RSTb,
	input  logic [io_map_pkg::REG_OFFSET_BITS-1:0]   reg_addr,
	input  logic [io_map_pkg::DATA_BITS-1:0]         wdata,
	input  logic                                     wr,
	input  logic [periph_regs_pkg::GPIO_IN_BITS-1:0]  gpio_in,
	output logic [io_map_pkg::DATA_BITS-1:0]         rdata,
	output logic [periph_regs_pkg::GPIO_OUT_BITS-1:0] gpio_out,
	output logic                                     edge_irq
);
	import io_map_pkg::*;
	import periph_regs_pkg::*;

	logic [GPIO_IN_BITS-1:0] sync_a;	// first flop, may be metastable
	logic [GPIO_IN_BITS-1:0] sync_b;
	logic [GPIO_IN_BITS-1:0] sync_prev;
	logic [GPIO_IN_BITS-1:0] irq_mask;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			gpio_out  <= '0;
			irq_mask  <= '0;
			sync_a    <= '0;
			sync_b    <= '0;
			sync_prev <= '0;
		end else begin
			sync_a    <= gpio_in;
			sync_b    <= sync_a;
			sync_prev <= sync_b;
			if (wr && reg_addr == GPIO_OUT)
				gpio_out <= wdata[GPIO_OUT_BITS-1:0];
			if (wr && reg_addr == GPIO_IRQ_MASK)
				irq_mask <= wdata[GPIO_IN_BITS-1:0];
		end
	end

	// edge seen the cycle the synchronised bit goes high
	assign edge_irq = |(sync_b & ~sync_prev & irq_mask);

	always_comb begin
		rdata = '0;
		case (reg_addr)
			GPIO_OUT:      rdata[GPIO_OUT_BITS-1:0] = gpio_out;
			GPIO_IN:       rdata[GPIO_IN_BITS-1:0]  = sync_b;
			GPIO_IRQ_MASK: rdata[GPIO_IN_BITS-1:0]  = irq_mask;
			default:       rdata = '0;
		endcase
	end

endmodule

// File: design/interrupt_controller.sv
// collects one cycle source pulses into pending bits
// interrupt rises when a pending source is enabled, irq_id names the lowest one
module interrupt_controller #(
	parameter int NUM_IRQ = 2
) (
	input  logic                                   CLK,
	input  logic                                   RSTb,
	input  logic [io_map_pkg::REG_OFFSET_BITS-1:0] reg_addr,
	input  logic [io_map_pkg::DATA_BITS-1:0]       wdata,
	input  logic                                   wr,
	input  logic [NUM_IRQ-1:0]                     src,
	output logic [io_map_pkg::DATA_BITS-1:0]       rdata,
	output logic                                   interrupt,
	output logic [periph_regs_pkg::IRQ_ID_BITS-1:0] irq_id
);
	import io_map_pkg::*;
	import periph_regs_pkg::*;

	logic [NUM_IRQ-1:0] pending;
	logic [NUM_IRQ-1:0] enable;
	logic [NUM_IRQ-1:0] clr;
	logic [NUM_IRQ-1:0] active;

	assign clr = (wr && reg_addr == IRQ_PENDING) ? wdata[NUM_IRQ-1:0] : '0;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pending <= '0;
			enable  <= '0;
		end else begin
			pending <= (pending & ~clr) | src;	// a new pulse beats the clear
			if (wr && reg_addr == IRQ_ENABLE)
				enable <= wdata[NUM_IRQ-1:0];
		end
	end

	assign active    = pending & enable;
	assign interrupt = |active;

	// scan down so the lowest active source is left in irq_id
	always_comb begin
		irq_id = '0;
		for (int i = NUM_IRQ - 1; i >= 0; i--) begin
			if (active[i])
				irq_id = i[IRQ_ID_BITS-1:0];
		end
	end

	always_comb begin
		rdata = '0;
		case (reg_addr)
			IRQ_PENDING: rdata[NUM_IRQ-1:0] = pending;
			IRQ_ENABLE:  rdata[NUM_IRQ-1:0] = enable;
			default:     rdata = '0;
		endcase
	end

endmodule

// File: design/port_controller.sv
// IO port controller, maps the CPU bus onto uart, gpio and interrupt regions
// writes land on the strobe edge, read data appears one cycle after the address
module port_controller #(
	parameter int CLOCK_FREQ = 8000000,
	parameter int BAUD_RATE  = 1000000
) (
	input  logic                                     CLK,
	input  logic                                     RSTb,
	input  logic [io_map_pkg::ADDR_BITS-1:0]         address,
	input  logic [io_map_pkg::DATA_BITS-1:0]         data_in,
	input  logic                                     mem_wr,
	input  logic                                     mem_rd,
	output logic [io_map_pkg::DATA_BITS-1:0]         data_out,
	input  logic [periph_regs_pkg::GPIO_IN_BITS-1:0]  gpio_in,
	output logic [periph_regs_pkg::GPIO_OUT_BITS-1:0] gpio_out,
	output logic                                     uart_tx,
	output logic                                     interrupt,
	output logic [periph_regs_pkg::IRQ_ID_BITS-1:0]   irq_id
);
	import io_map_pkg::*;
	import periph_regs_pkg::*;

	localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
	localparam int NUM_IRQ = 2;

	logic [REGION_BITS-1:0] region;
	logic [REGION_BITS-1:0] region_q;	// region of last cycle's address
	logic [REG_OFFSET_BITS-1:0] reg_addr;
	logic uart_wr, gpio_wr, irq_wr;
	logic [DATA_BITS-1:0] uart_rdata, gpio_rdata, irq_rdata;
	logic [DATA_BITS-1:0] rd_sel;
	logic [DATA_BITS-1:0] rd_data;
	logic mapped_q;
	logic baud_tick, uart_run, tx_done, gpio_edge;
	logic [NUM_IRQ-1:0] irq_src;

	assign region   = address[ADDR_BITS-1 -: REGION_BITS];
	assign reg_addr = address[REG_OFFSET_BITS-1:0];

	assign uart_wr = mem_wr && (region == REGION_UART);
	assign gpio_wr = mem_wr && (region == REGION_GPIO);
	assign irq_wr  = mem_wr && (region == REGION_IRQ);

	always_comb begin
		case (region)
			REGION_UART: rd_sel = uart_rdata;
			REGION_GPIO: rd_sel = gpio_rdata;
			REGION_IRQ:  rd_sel = irq_rdata;
			default:     rd_sel = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			rd_data  <= '0;
			region_q <= '0;
		end else begin
			region_q <= region;
			if (mem_rd)
				rd_data <= rd_sel;	// hold on idle cycles
		end
	end

	assign mapped_q = (region_q == REGION_UART) || (region_q == REGION_GPIO) ||
		(region_q == REGION_IRQ);
	assign data_out = mapped_q ? rd_data : '0;

	assign irq_src[IRQ_SRC_UART] = tx_done;
	assign irq_src[IRQ_SRC_GPIO] = gpio_edge;

	uart_tx_fsm uart0 (
		.CLK(CLK), .RSTb(RSTb), .reg_addr(reg_addr), .wdata(data_in), .wr(uart_wr),
		.baud_tick(baud_tick), .run(uart_run), .rdata(uart_rdata), .uart_tx(uart_tx),
		.tx_done(tx_done)
	);

	baud_timer #(.CLKS_PER_BIT(CLKS_PER_BIT)) baud0 (
		.CLK(CLK), .RSTb(RSTb), .run(uart_run), .baud_tick(baud_tick)
	);

	gpio_port gpio0 (
		.CLK(CLK), .RSTb(RSTb), .reg_addr(reg_addr), .wdata(data_in), .wr(gpio_wr),
		.gpio_in(gpio_in), .rdata(gpio_rdata), .gpio_out(gpio_out), .edge_irq(gpio_edge)
	);

	interrupt_controller #(.NUM_IRQ(NUM_IRQ)) irq0 (
		.CLK(CLK), .RSTb(RSTb), .reg_addr(reg_addr), .wdata(data_in), .wr(irq_wr),
		.src(irq_src), .rdata(irq_rdata), .interrupt(interrupt), .irq_id(irq_id)
	);

endmodule

// File: verif/io_asserts.sv
// concurrent assertions on the bus, the UART line and the interrupt output
// bound into port_controller and counting failed checks in fail_count
module io_asserts (
	input logic                             CLK,
	input logic                             RSTb,
	input logic [io_map_pkg::ADDR_BITS-1:0] address,
	input logic [io_map_pkg::DATA_BITS-1:0] data_in,
	input logic                             mem_wr,
	input logic                             mem_rd,
	input logic [io_map_pkg::DATA_BITS-1:0] data_out,
	input logic                             uart_run,
	input logic                             uart_tx,
	input logic                             interrupt
);
	import io_map_pkg::*;
	import periph_regs_pkg::*;

	int fail_count;
	logic unmapped;
	logic [1:0] enable_seen;	// enable register as written over the bus

	initial fail_count = 0;

	assign unmapped = !(address[ADDR_BITS-1 -: 4] inside {REGION_UART, REGION_GPIO, REGION_IRQ});

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			enable_seen <= '0;
		end else if (mem_wr && address[ADDR_BITS-1 -: 4] == REGION_IRQ &&
				address[3:0] == IRQ_ENABLE) begin
			enable_seen <= data_in[1:0];
		end
	end

	idle_line_high: assert property (@(posedge CLK) disable iff (!RSTb) !uart_run |-> uart_tx)
		else begin
			fail_count++;
			$error("uart_tx is low while the UART is idle");
		end

	no_irq_when_disabled: assert property (@(posedge CLK) disable iff (!RSTb)
		enable_seen == '0 |-> !interrupt)
		else begin
			fail_count++;
			$error("interrupt is high with every source disabled");
		end

	unmapped_reads_zero: assert property (@(posedge CLK) disable iff (!RSTb)
		(mem_rd || mem_wr) && unmapped |=> data_out == '0)
		else begin
			fail_count++;
			$error("data_out is not zero after an unmapped access");
		end

endmodule

bind port_controller io_asserts asserts0 (
	.CLK(CLK), .RSTb(RSTb), .address(address), .data_in(data_in), .mem_wr(mem_wr),
	.mem_rd(mem_rd), .data_out(data_out), .uart_run(uart_run), .uart_tx(uart_tx),
	.interrupt(interrupt)
);

// File: verif/io_checker.sv
// reference model of the IO space, sits beside the DUT and compares its outputs
// bus inputs are taken on the rising edge, outputs checked on the falling edge
module io_checker #(
	parameter int BIT_CLKS = 8
) (
	input  logic                                      CLK,
	input  logic                                      RSTb,
	input  logic [io_map_pkg::ADDR_BITS-1:0]          address,
	input  logic [io_map_pkg::DATA_BITS-1:0]          data_in,
	input  logic                                      mem_wr,
	input  logic                                      mem_rd,
	input  logic [io_map_pkg::DATA_BITS-1:0]          data_out,
	input  logic [periph_regs_pkg::GPIO_IN_BITS-1:0]  gpio_in,
	input  logic [periph_regs_pkg::GPIO_OUT_BITS-1:0] gpio_out,
	input  logic                                      uart_tx,
	input  logic                                      interrupt,
	input  logic [periph_regs_pkg::IRQ_ID_BITS-1:0]   irq_id,
	output int                                        errors,
	output int                                        checks
);
	import io_map_pkg::*;
	import periph_regs_pkg::*;

	localparam int FRAME_CLKS = 10 * BIT_CLKS;	// start, 8 data, stop

	logic [GPIO_OUT_BITS-1:0] m_out;
	logic [GPIO_IN_BITS-1:0] m_mask;
	logic [GPIO_IN_BITS-1:0] s1, s2, s3;	// two stage sync plus edge history
	logic [1:0] m_pend, m_en;
	int tx_left;	// cycles left in the frame on the line
	logic [7:0] tx_byte, rx_byte;
	logic live, rd_q;
	logic [DATA_BITS-1:0] exp_q;

	initial begin
		errors = 0;
		checks = 0;
	end

	task automatic compare(input logic [DATA_BITS-1:0] got, input logic [DATA_BITS-1:0] exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic logic [DATA_BITS-1:0] expect_read(input logic [ADDR_BITS-1:0] a);
		logic [DATA_BITS-1:0] v;
		v = '0;
		case (a[ADDR_BITS-1 -: 4])
			REGION_UART: v[0] = (a[3:0] == UART_STATUS) && (tx_left > 0);
			REGION_GPIO: begin
				if (a[3:0] == GPIO_OUT)
					v[GPIO_OUT_BITS-1:0] = m_out;
				if (a[3:0] == GPIO_IN)
					v[GPIO_IN_BITS-1:0] = s2;
				if (a[3:0] == GPIO_IRQ_MASK)
					v[GPIO_IN_BITS-1:0] = m_mask;
			end
			REGION_IRQ: begin
				if (a[3:0] == IRQ_PENDING)
					v[1:0] = m_pend;
				if (a[3:0] == IRQ_ENABLE)
					v[1:0] = m_en;
			end
			default: v = '0;	// unmapped
		endcase
		return v;
	endfunction

	always @(posedge CLK) begin : model_update
		logic [3:0] region;
		logic [3:0] off;
		logic [1:0] set;
		logic [1:0] clr;
		region = address[ADDR_BITS-1 -: 4];
		off = address[3:0];
		live <= RSTb;
		if (!RSTb) begin
			m_out   <= '0;
			m_mask  <= '0;
			{s1, s2, s3} <= '0;
			m_pend  <= '0;
			m_en    <= '0;
			tx_left <= 0;
			rd_q    <= 1'b0;
		end else begin
			rd_q  <= mem_rd;
			exp_q <= expect_read(address);
			s1 <= gpio_in;
			s2 <= s1;
			s3 <= s2;
			set = '0;
			set[IRQ_SRC_GPIO] = |(s2 & ~s3 & m_mask);
			set[IRQ_SRC_UART] = (tx_left == 1);	// stop bit ends on this edge
			clr = (mem_wr && region == REGION_IRQ && off == IRQ_PENDING) ? data_in[1:0] : '0;
			m_pend <= (m_pend & ~clr) | set;
			if (mem_wr && region == REGION_IRQ && off == IRQ_ENABLE)
				m_en <= data_in[1:0];
			if (mem_wr && region == REGION_GPIO && off == GPIO_OUT)
				m_out <= data_in[GPIO_OUT_BITS-1:0];
			if (mem_wr && region == REGION_GPIO && off == GPIO_IRQ_MASK)
				m_mask <= data_in[GPIO_IN_BITS-1:0];
			if (tx_left > 0) begin
				tx_left <= tx_left - 1;	// writes while busy are dropped
			end else if (mem_wr && region == REGION_UART && off == UART_TXDATA) begin
				tx_left <= FRAME_CLKS;
				tx_byte <= data_in[7:0];
			end
		end
	end

	always @(negedge CLK) begin : compare_outputs
		logic [1:0] act;
		int pos;
		act = m_pend & m_en;
		if (live) begin
			if (rd_q)
				compare(data_out, exp_q, "read data");
			compare(gpio_out, m_out, "gpio_out");
			compare(interrupt, |act, "interrupt");
			compare(irq_id, act[0] ? 2'd0 : (act[1] ? 2'd1 : 2'd0), "irq_id");
			if (tx_left == 0) begin
				compare(uart_tx, 1'b1, "uart idle level");
			end else begin
				pos = FRAME_CLKS - tx_left;
				if (pos % BIT_CLKS == BIT_CLKS / 2) begin	// mid bit
					if (pos < BIT_CLKS) begin
						compare(uart_tx, 1'b0, "uart start bit");
					end else if (pos < 9 * BIT_CLKS) begin
						rx_byte[pos / BIT_CLKS - 1] = uart_tx;	// lsb first
					end else begin
						compare(uart_tx, 1'b1, "uart stop bit");
						compare(rx_byte, tx_byte, "uart byte");
					end
				end
			end
		end
	end

endmodule

// File: verif/io_tb.sv
// testbench for the IO port controller
// random bus traffic from a fixed seed, io_checker does the comparing
module io_tb;
	import io_map_pkg::*;
	import periph_regs_pkg::*;

	localparam int PERIOD = 40;
	localparam int CLOCK_FREQ = 8000000;
	localparam int BAUD_RATE = 1000000;

	logic CLK, RSTb;
	logic [ADDR_BITS-1:0] address;
	logic [DATA_BITS-1:0] data_in, data_out, rd_val;
	logic mem_wr, mem_rd, uart_tx, interrupt;
	logic [GPIO_IN_BITS-1:0] gpio_in;
	logic [GPIO_OUT_BITS-1:0] gpio_out;
	logic [IRQ_ID_BITS-1:0] irq_id;
	logic [31:0] rnd;
	int chk_errors, chk_count, timeouts, tests_done, seed, r;

	port_controller #(.CLOCK_FREQ(CLOCK_FREQ), .BAUD_RATE(BAUD_RATE)) dut0 (.*);

	io_checker #(.BIT_CLKS(CLOCK_FREQ / BAUD_RATE)) chk0 (
		.CLK(CLK), .RSTb(RSTb), .address(address), .data_in(data_in), .mem_wr(mem_wr),
		.mem_rd(mem_rd), .data_out(data_out), .gpio_in(gpio_in), .gpio_out(gpio_out),
		.uart_tx(uart_tx), .interrupt(interrupt), .irq_id(irq_id),
		.errors(chk_errors), .checks(chk_count)
	);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	function automatic logic [ADDR_BITS-1:0] reg_at(input logic [3:0] region,
			input logic [3:0] off);
		return {region, 8'h00, off};
	endfunction

	function automatic int total_errors();
		return chk_errors + dut0.asserts0.fail_count + timeouts;
	endfunction

	// each bus task starts and ends just after a falling edge
	task automatic write_reg(input logic [ADDR_BITS-1:0] a, input logic [DATA_BITS-1:0] d);
		address = a;
		data_in = d;
		mem_wr = 1'b1;
		@(negedge CLK);
		mem_wr = 1'b0;
	endtask

	task automatic read_reg(input logic [ADDR_BITS-1:0] a, output logic [DATA_BITS-1:0] v);
		address = a;
		mem_rd = 1'b1;
		@(negedge CLK);
		mem_rd = 1'b0;
		v = data_out;	// registered, one cycle after the address
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge CLK);
	endtask

	task automatic poll_reg(input logic [ADDR_BITS-1:0] a, input logic [DATA_BITS-1:0] mask,
			input logic [DATA_BITS-1:0] want, input int limit, input string what);
		logic [DATA_BITS-1:0] v;
		int n;
		n = 0;
		read_reg(a, v);
		while ((v & mask) !== want && n < limit) begin
			read_reg(a, v);
			n++;
		end
		if ((v & mask) !== want) begin
			timeouts++;
			$display("timed out after %0d reads waiting for %s", limit, what);
		end
	endtask

	task automatic wait_irq(input logic want, input int limit, input string what);
		int n;
		n = 0;
		while (interrupt !== want && n < limit) begin
			idle(1);
			n++;
		end
		if (interrupt !== want) begin
			timeouts++;
			$display("timed out after %0d cycles waiting for %s", limit, what);
		end
	endtask

	task automatic raise_random_input();
		rnd = $random(seed);
		gpio_in[$unsigned(rnd) % GPIO_IN_BITS] = 1'b1;
	endtask

	task automatic end_test(input string name);
		tests_done++;
		$display("test %0d %s finished, errors so far %0d", tests_done, name, total_errors());
	endtask

	initial begin
		seed = 31122;
		timeouts = 0;
		tests_done = 0;
		RSTb = 1'b0;
		address = '0;
		data_in = '0;
		mem_wr = 1'b0;
		mem_rd = 1'b0;
		gpio_in = '0;
		repeat (4) @(negedge CLK);
		RSTb = 1'b1;
		idle(1);

		repeat (8) begin
			rnd = $random(seed);
			write_reg(reg_at(REGION_GPIO, GPIO_OUT), rnd[15:0]);
			read_reg(reg_at(REGION_GPIO, GPIO_OUT), rd_val);
		end
		end_test("gpio output");

		repeat (8) begin
			rnd = $random(seed);
			gpio_in = rnd[GPIO_IN_BITS-1:0];	// mask is clear, no edge events
			idle(3);
			read_reg(reg_at(REGION_GPIO, GPIO_IN), rd_val);
		end
		gpio_in = '0;
		idle(3);
		end_test("gpio input");

		repeat (3) begin
			rnd = $random(seed);
			write_reg(reg_at(REGION_UART, UART_TXDATA), {8'h00, rnd[7:0]});
			read_reg(reg_at(REGION_UART, UART_STATUS), rd_val);
			write_reg(reg_at(REGION_UART, UART_TXDATA), {8'h00, rnd[15:8]});	// dropped
			poll_reg(reg_at(REGION_UART, UART_STATUS), 16'h0001, 16'h0000, 200, "frame end");
		end
		end_test("uart frames");

		write_reg(reg_at(REGION_IRQ, IRQ_PENDING), 16'h0003);	// uart done left pending
		write_reg(reg_at(REGION_GPIO, GPIO_IRQ_MASK), 16'h003f);
		write_reg(reg_at(REGION_IRQ, IRQ_ENABLE), 16'h0003);
		raise_random_input();
		wait_irq(1'b1, 10, "the gpio interrupt");
		write_reg(reg_at(REGION_IRQ, IRQ_PENDING), 16'h0002);
		wait_irq(1'b0, 4, "the gpio interrupt to clear");
		gpio_in = '0;
		idle(3);
		end_test("gpio interrupt");

		raise_random_input();
		wait_irq(1'b1, 10, "the gpio interrupt");
		rnd = $random(seed);
		write_reg(reg_at(REGION_UART, UART_TXDATA), {8'h00, rnd[7:0]});
		poll_reg(reg_at(REGION_IRQ, IRQ_PENDING), 16'h0001, 16'h0001, 200, "uart done");
		idle(2);	// both pending, lowest source wins
		write_reg(reg_at(REGION_IRQ, IRQ_ENABLE), 16'h0000);
		idle(4);
		write_reg(reg_at(REGION_IRQ, IRQ_PENDING), 16'h0003);
		gpio_in = '0;
		idle(3);
		end_test("uart interrupt and priority");

		repeat (24) begin
			rnd = $random(seed);
			r = 2 + ($unsigned(rnd[7:0]) % 13);
			if (r >= 7)
				r++;	// skip the irq region
			if (rnd[20])
				write_reg({r[3:0], rnd[19:8]}, rnd[31:16]);
			else
				read_reg({r[3:0], rnd[19:8]}, rd_val);
		end
		read_reg(reg_at(REGION_GPIO, GPIO_OUT), rd_val);
		read_reg(reg_at(REGION_GPIO, GPIO_IRQ_MASK), rd_val);
		read_reg(reg_at(REGION_IRQ, IRQ_PENDING), rd_val);
		read_reg(reg_at(REGION_IRQ, IRQ_ENABLE), rd_val);
		read_reg(reg_at(REGION_UART, UART_STATUS), rd_val);
		idle(2);
		end_test("unmapped regions");

		$display("tests %0d, checks %0d, errors %0d", tests_done, chk_count, total_errors());
		if (total_errors() == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: sources.f
design/io_map_pkg.sv
design/periph_regs_pkg.sv
design/baud_timer.sv
design/uart_tx_fsm.sv
design/gpio_port.sv
design/interrupt_controller.sv
design/port_controller.sv
verif/io_asserts.sv
verif/io_checker.sv
verif/io_tb.sv
